// ==== tb.f ====
hw/mem_tlul_pkg.sv
hw/sram_bytemask.sv
hw/tlul_sram_adapter.sv
hw/mem_tlul.sv
testbench/tb_mem_tlul.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the TL-UL memory testbench with Verilator and runs it into a log file

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
TOP=tb_mem_tlul

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator was not found in PATH"
  exit 1
fi

verilator --binary --timing -f tb.f --top-module "$TOP" -Mdir "$BUILD_DIR"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi

if ! grep -q "RESULT: PASS" "$LOG"; then
  echo "Simulation ended without a result line, see $LOG"
  exit 1
fi

exit 0

// ==== testbench/tb_mem_tlul.sv ====
`default_nettype none

module tb_mem_tlul;
  import mem_tlul_pkg::*;

  localparam int SramAw   = 11;
  localparam int Depth    = 2 ** SramAw;
  localparam int Seed     = 32'h4e211fa8;
  localparam int NumWords = 16;  // Size of the pool of written word addresses
  localparam int NumErr   = 8;
  localparam int NumRand  = 64;
  // Pool words are written and read in two tests and read once more after the error test
  localparam int NumTxn        = 5 * NumWords + 2 * NumErr + NumRand;
  localparam int TimeoutCycles = NumTxn * 40 + 200;

  logic               clk_i       = 1'b0;
  logic               rst_ni      = 1'b0;
  logic               a_valid_i   = 1'b0;
  logic               a_ready_o;
  logic [2:0]         a_opcode_i  = 3'h0;
  logic [TlAddrW-1:0] a_address_i = '0;
  logic [TlSrcW-1:0]  a_source_i  = '0;
  logic [TlMaskW-1:0] a_mask_i    = '0;
  logic [TlDataW-1:0] a_data_i    = '0;
  logic               d_valid_o;
  logic               d_ready_i   = 1'b1;
  logic [2:0]         d_opcode_o;
  logic [TlSrcW-1:0]  d_source_o;
  logic [TlDataW-1:0] d_data_o;
  logic               d_error_o;

  logic [TlDataW-1:0] shadow [Depth];
  logic [TlAddrW-1:0] pool [NumWords];
  logic [43:0]        exp_q [$];  // {opcode, source, data, error} per accepted request

  int   chk_cnt    = 0;
  int   err_cnt    = 0;
  logic started    = 1'b0;
  logic bp_en      = 1'b0;
  logic final_chk  = 1'b0;
  logic final_done = 1'b0;

  always #4 clk_i = ~clk_i;

  mem_tlul #(
    .SramAw (SramAw)
  ) mem_tlul_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .a_valid_i   (a_valid_i),
    .a_ready_o   (a_ready_o),
    .a_opcode_i  (a_opcode_i),
    .a_address_i (a_address_i),
    .a_source_i  (a_source_i),
    .a_mask_i    (a_mask_i),
    .a_data_i    (a_data_i),
    .d_valid_o   (d_valid_o),
    .d_ready_i   (d_ready_i),
    .d_opcode_o  (d_opcode_o),
    .d_source_o  (d_source_o),
    .d_data_o    (d_data_o),
    .d_error_o   (d_error_o)
  );

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("MISMATCH at time %0t: %s is %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  // Expected reply for one request, and the shadow memory update for a valid Put
  function automatic void ref_access(input logic [2:0] op, input logic [TlAddrW-1:0] addr,
                                     input logic [TlMaskW-1:0] mask,
                                     input logic [TlDataW-1:0] data, output logic [2:0] exp_op,
                                     output logic [TlDataW-1:0] exp_data, output logic exp_err);
    logic [SramAw-1:0] waddr;
    logic              is_put;
    logic              in_range;
    waddr    = addr[SramAw+1:2];
    is_put   = (op == OpPutFullData) || (op == OpPutPartialData);
    in_range = (addr[TlAddrW-1:SramAw+2] == '0);
    exp_err  = !(is_put || (op == OpGet)) || !in_range;
    exp_op   = is_put ? OpAccessAck : OpAccessAckData;  // Unknown opcodes count as reads
    exp_data = '0;
    if (!exp_err && is_put) begin
      for (int b = 0; b < TlMaskW; b++) begin
        if (mask[b]) shadow[waddr][8*b +: 8] = data[8*b +: 8];
      end
    end else if (!exp_err) begin
      exp_data = shadow[waddr];
    end
  endfunction

  // Random back-pressure on the D channel while enabled
  always @(posedge clk_i) begin
    if (bp_en) d_ready_i <= ($urandom % 4) != 0;
    else d_ready_i <= 1'b1;
  end

  // Snoops A-channel acceptance for the expected reply and compares each D handshake
  always @(posedge clk_i) begin : compare
    logic [2:0]         exp_op;
    logic [TlDataW-1:0] exp_data;
    logic               exp_err;
    logic [43:0]        exp_rsp;
    if (rst_ni && !started) begin
      check_val("d_valid_o after reset", 32'(d_valid_o), 32'd0);
      check_val("a_ready_o after reset", 32'(a_ready_o), 32'd1);
    end
    if (rst_ni && a_valid_i && a_ready_o) begin
      ref_access(a_opcode_i, a_address_i, a_mask_i, a_data_i, exp_op, exp_data, exp_err);
      exp_q.push_back({exp_op, a_source_i, exp_data, exp_err});
    end
    if (rst_ni && d_valid_o && d_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("ERROR at time %0t: a reply arrived with no request outstanding", $time);
        err_cnt++;
      end else begin
        exp_rsp = exp_q.pop_front();
        check_val("d_opcode_o", 32'(d_opcode_o), 32'(exp_rsp[43:41]));
        check_val("d_source_o", 32'(d_source_o), 32'(exp_rsp[40:33]));
        check_val("d_data_o", d_data_o, exp_rsp[32:1]);
        check_val("d_error_o", 32'(d_error_o), 32'(exp_rsp[0]));
      end
    end
    if (final_chk && !final_done) begin
      check_val("replies left in queue", 32'(exp_q.size()), 32'd0);
      final_done = 1'b1;
    end
  end

  task automatic send_req(input logic [2:0] op, input logic [TlAddrW-1:0] addr,
                          input logic [TlMaskW-1:0] mask, input logic [TlDataW-1:0] data);
    repeat ($urandom % 4) @(posedge clk_i);  // Random idle gap on the A channel
    @(posedge clk_i);
    a_valid_i   <= 1'b1;
    a_opcode_i  <= op;
    a_address_i <= addr;
    a_source_i  <= 8'($urandom);
    a_mask_i    <= mask;
    a_data_i    <= data;
    started     <= 1'b1;
    @(posedge clk_i);
    while (!a_ready_o) @(posedge clk_i);
    a_valid_i <= 1'b0;
  endtask

  task automatic end_test(input string name, input int err_before);
    @(posedge clk_i);
    while (exp_q.size() != 0) @(posedge clk_i);
    $display("test %s finished: %0d errors", name, err_cnt - err_before);
  endtask

  task automatic read_pool();
    for (int i = 0; i < NumWords; i++) send_req(OpGet, pool[i], 4'h0, '0);
  endtask

  task automatic run_full_words();
    int err_before;
    int w;
    err_before = err_cnt;
    for (int i = 0; i < NumWords; i++) begin
      w       = int'($urandom % Depth);
      pool[i] = 32'(w) << 2;
      send_req(OpPutFullData, pool[i], 4'hf, 32'($urandom));
    end
    read_pool();
    end_test("full_word_write_read", err_before);
  endtask

  task automatic run_partial_writes();
    int err_before;
    err_before = err_cnt;
    for (int i = 0; i < NumWords; i++) begin
      send_req(OpPutPartialData, pool[i], 4'($urandom), 32'($urandom));
    end
    read_pool();
    end_test("partial_write", err_before);
  endtask

  task automatic run_error_requests();
    logic [2:0]         bad_ops [5] = '{3'h2, 3'h3, 3'h5, 3'h6, 3'h7};
    logic [TlAddrW-1:0] addr;
    int                 err_before;
    err_before = err_cnt;
    for (int i = 0; i < NumErr; i++) begin
      send_req(bad_ops[i % 5], pool[i % NumWords], 4'hf, 32'($urandom));
    end
    for (int i = 0; i < NumErr; i++) begin
      // One address bit above the memory range is set
      addr = pool[i % NumWords] | (32'd1 << (SramAw + 2 + ($urandom % (32 - SramAw - 2))));
      send_req(OpPutFullData, addr, 4'hf, 32'($urandom));
    end
    read_pool();  // Content must be unchanged by the rejected requests
    end_test("error_requests", err_before);
  endtask

  task automatic run_random_traffic();
    int err_before;
    int idx;
    int kind;
    err_before = err_cnt;
    bp_en <= 1'b1;
    for (int i = 0; i < NumRand; i++) begin
      idx  = int'($urandom % NumWords);
      kind = int'($urandom % 3);
      if (kind == 0) send_req(OpGet, pool[idx], 4'h0, '0);
      else if (kind == 1) send_req(OpPutFullData, pool[idx], 4'hf, 32'($urandom));
      else send_req(OpPutPartialData, pool[idx], 4'($urandom), 32'($urandom));
    end
    end_test("random_backpressure", err_before);
    bp_en <= 1'b0;
  endtask

  initial begin : main
    void'($urandom(Seed));
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (4) @(posedge clk_i);
    end_test("reset_state", 0);
    run_full_words();
    run_partial_writes();
    run_error_requests();
    run_random_traffic();
    final_chk <= 1'b1;
    repeat (2) @(posedge clk_i);
    if (!final_done) $display("ERROR: the end-of-run checks never ran");
    $display("checks passed: %0d, errors: %0d", chk_cnt - err_cnt, err_cnt);
    if (err_cnt == 0 && final_done) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (TimeoutCycles) @(posedge clk_i);
    $display("ERROR: timed out after %0d cycles waiting for the DUT", TimeoutCycles);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/mem_tlul.sv ====
`default_nettype none

module mem_tlul #(
  parameter int unsigned SramAw = 11
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  // TL-UL A channel
  input  logic                             a_valid_i,
  output logic                             a_ready_o,
  input  logic [2:0]                       a_opcode_i,
  input  logic [mem_tlul_pkg::TlAddrW-1:0] a_address_i,
  input  logic [mem_tlul_pkg::TlSrcW-1:0]  a_source_i,
  input  logic [mem_tlul_pkg::TlMaskW-1:0] a_mask_i,
  input  logic [mem_tlul_pkg::TlDataW-1:0] a_data_i,

  // TL-UL D channel
  output logic                             d_valid_o,
  input  logic                             d_ready_i,
  output logic [2:0]                       d_opcode_o,
  output logic [mem_tlul_pkg::TlSrcW-1:0]  d_source_o,
  output logic [mem_tlul_pkg::TlDataW-1:0] d_data_o,
  output logic                             d_error_o
);
  import mem_tlul_pkg::*;

  logic               sram_req;
  logic               sram_we;
  logic [SramAw-1:0]  sram_addr;
  logic [TlDataW-1:0] sram_wdata;
  logic [TlDataW-1:0] sram_wmask;
  logic [TlDataW-1:0] sram_rdata;

  logic               req_q;     // SRAM was accessed on the previous edge
  logic               rvalid_q;  // Lines up with rdata_q
  logic [TlDataW-1:0] rdata_q;

  // Valid follows each request by two edges, reads and writes alike
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q    <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      req_q    <= sram_req;
      rvalid_q <= req_q;
    end
  end

  // Retimes the SRAM output before it reaches the adapter
  always_ff @(posedge clk_i) begin
    rdata_q <= sram_rdata;
  end

  tlul_sram_adapter #(
    .SramAw (SramAw)
  ) u_adapter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .a_valid_i    (a_valid_i),
    .a_ready_o    (a_ready_o),
    .a_opcode_i   (a_opcode_i),
    .a_address_i  (a_address_i),
    .a_source_i   (a_source_i),
    .a_mask_i     (a_mask_i),
    .a_data_i     (a_data_i),
    .d_valid_o    (d_valid_o),
    .d_ready_i    (d_ready_i),
    .d_opcode_o   (d_opcode_o),
    .d_source_o   (d_source_o),
    .d_data_o     (d_data_o),
    .d_error_o    (d_error_o),
    .sram_req_o   (sram_req),
    .sram_we_o    (sram_we),
    .sram_addr_o  (sram_addr),
    .sram_wdata_o (sram_wdata),
    .sram_wmask_o (sram_wmask),
    .rdata_i      (rdata_q),
    .rvalid_i     (rvalid_q)
  );

  sram_bytemask #(
    .SramAw (SramAw)
  ) u_sram (
    .clk_i   (clk_i),
    .req_i   (sram_req),
    .we_i    (sram_we),
    .addr_i  (sram_addr),
    .wdata_i (sram_wdata),
    .wmask_i (sram_wmask),
    .rdata_o (sram_rdata)
  );

endmodule

`default_nettype wire

// ==== hw/tlul_sram_adapter.sv ====
`default_nettype none

module tlul_sram_adapter #(
  parameter int unsigned SramAw = 11
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  // TL-UL A channel
  input  logic                             a_valid_i,
  output logic                             a_ready_o,
  input  logic [2:0]                       a_opcode_i,
  input  logic [mem_tlul_pkg::TlAddrW-1:0] a_address_i,
  input  logic [mem_tlul_pkg::TlSrcW-1:0]  a_source_i,
  input  logic [mem_tlul_pkg::TlMaskW-1:0] a_mask_i,
  input  logic [mem_tlul_pkg::TlDataW-1:0] a_data_i,

  // TL-UL D channel
  output logic                             d_valid_o,
  input  logic                             d_ready_i,
  output logic [2:0]                       d_opcode_o,
  output logic [mem_tlul_pkg::TlSrcW-1:0]  d_source_o,
  output logic [mem_tlul_pkg::TlDataW-1:0] d_data_o,
  output logic                             d_error_o,

  // SRAM command and registered read return
  output logic                             sram_req_o,
  output logic                             sram_we_o,
  output logic [SramAw-1:0]                sram_addr_o,
  output logic [mem_tlul_pkg::TlDataW-1:0] sram_wdata_o,
  output logic [mem_tlul_pkg::TlDataW-1:0] sram_wmask_o,
  input  logic [mem_tlul_pkg::TlDataW-1:0] rdata_i,
  input  logic                             rvalid_i
);
  import mem_tlul_pkg::*;

  // Transaction FSM encoding
  localparam logic [1:0] StIdle  = 2'd0;  // Ready for a new request
  localparam logic [1:0] StIssue = 2'd1;  // Command on the SRAM port, or error decided
  localparam logic [1:0] StWait  = 2'd2;  // Waiting for the registered read return
  localparam logic [1:0] StResp  = 2'd3;  // Reply held on the D channel

  logic [1:0]         state_q;
  logic [1:0]         state_d;
  logic               a_fire;
  logic               d_fire;
  logic               a_is_put;
  logic               op_ok;
  logic               addr_ok;
  logic [TlDataW-1:0] a_wmask;

  logic               is_read_q;
  logic               err_q;
  logic               we_q;
  logic [TlSrcW-1:0]  source_q;
  logic [SramAw-1:0]  addr_q;
  logic [TlDataW-1:0] wdata_q;
  logic [TlDataW-1:0] wmask_q;
  logic [TlDataW-1:0] d_data_q;

  assign a_ready_o = (state_q == StIdle);
  assign a_fire    = a_valid_i && a_ready_o;
  assign d_valid_o = (state_q == StResp);
  assign d_fire    = d_valid_o && d_ready_i;

  // Request checks, evaluated on the A fields at acceptance
  assign a_is_put = (a_opcode_i == OpPutFullData) || (a_opcode_i == OpPutPartialData);
  assign op_ok    = a_is_put || (a_opcode_i == OpGet);
  assign addr_ok  = ((a_address_i >> (SramAw + 2)) == '0);  // Works for any depth

  // Each byte-lane enable becomes a full byte of the SRAM bit mask
  always_comb begin
    for (int unsigned i = 0; i < TlMaskW; i++) begin
      a_wmask[i*TlByteW +: TlByteW] = {TlByteW{a_mask_i[i]}};
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      StIdle: begin
        if (a_fire) state_d = StIssue;
      end
      StIssue: begin
        state_d = err_q ? StResp : StWait;  // Errors skip the memory
      end
      StWait: begin
        if (rvalid_i) state_d = StResp;
      end
      StResp: begin
        if (d_fire) state_d = StIdle;
      end
      default: begin
        state_d = StIdle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= StIdle;
      is_read_q <= 1'b0;
      err_q     <= 1'b0;
      we_q      <= 1'b0;
      source_q  <= '0;
    end else begin
      state_q <= state_d;
      if (a_fire) begin
        // Unsupported opcodes are answered like a Get
        is_read_q <= !a_is_put;
        err_q     <= !(op_ok && addr_ok);
        we_q      <= a_is_put;
        source_q  <= a_source_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fire) begin
      addr_q  <= a_address_i[SramAw+1:2];
      wdata_q <= a_data_i;
      wmask_q <= a_is_put ? a_wmask : '0;  // A Get writes nothing
    end
  end

  // Reply data is zero for writes and for errors
  always_ff @(posedge clk_i) begin
    if ((state_q == StIssue) && err_q) begin
      d_data_q <= '0;
    end else if ((state_q == StWait) && rvalid_i) begin
      d_data_q <= is_read_q ? rdata_i : '0;
    end
  end

  // One command cycle per valid request
  assign sram_req_o   = (state_q == StIssue) && !err_q;
  assign sram_we_o    = we_q;
  assign sram_addr_o  = addr_q;
  assign sram_wdata_o = wdata_q;
  assign sram_wmask_o = wmask_q;

  assign d_opcode_o = is_read_q ? OpAccessAckData : OpAccessAck;
  assign d_source_o = source_q;
  assign d_data_o   = d_data_q;
  assign d_error_o  = err_q;

endmodule

`default_nettype wire

// ==== hw/sram_bytemask.sv ====
`default_nettype none

module sram_bytemask #(
  parameter int unsigned SramAw = 11
) (
  input  logic                             clk_i,
  input  logic                             req_i,
  input  logic                             we_i,
  input  logic [SramAw-1:0]                addr_i,
  input  logic [mem_tlul_pkg::TlDataW-1:0] wdata_i,
  input  logic [mem_tlul_pkg::TlDataW-1:0] wmask_i,  // Bit mask, one bit per data bit
  output logic [mem_tlul_pkg::TlDataW-1:0] rdata_o
);
  import mem_tlul_pkg::*;

  localparam int unsigned Depth = 2 ** SramAw;

  logic [TlDataW-1:0] mem [Depth];
  logic [TlDataW-1:0] cur_word;
  logic [TlDataW-1:0] new_word;

  assign cur_word = mem[addr_i];

  // Bits outside the mask keep their stored value
  assign new_word = (cur_word & ~wmask_i) | (wdata_i & wmask_i);

  // Read happens on every request, returning the word as it was before the write
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= cur_word;
      if (we_i) begin
        mem[addr_i] <= new_word;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/mem_tlul_pkg.sv ====
`default_nettype none

package mem_tlul_pkg;

  // Bus and memory word width
  localparam int unsigned TlDataW = 32;

  // Byte address width on the A channel
  localparam int unsigned TlAddrW = 32;

  localparam int unsigned TlSrcW  = 8;  // Source ID carried from A to D
  localparam int unsigned TlMaskW = TlDataW / 8;  // One mask bit per byte lane

  // Width of one byte lane, used to expand the A-channel mask
  localparam int unsigned TlByteW = TlDataW / TlMaskW;

  // A-channel opcodes that the device accepts
  localparam logic [2:0] OpPutFullData    = 3'h0;
  localparam logic [2:0] OpPutPartialData = 3'h1;
  localparam logic [2:0] OpGet            = 3'h4;

  // D-channel reply opcodes
  localparam logic [2:0] OpAccessAck     = 3'h0;  // Reply to a Put
  localparam logic [2:0] OpAccessAckData = 3'h1;  // Reply to a Get, carries data

endpackage

`default_nettype wire
